//--- lc3b_types.sv
package lc3b_types;

	// data words and byte addresses are both 16 bits wide.
	typedef logic [15:0] lc3b_word;

	// bit 0 enables the low byte, bit 1 the high byte.
	typedef logic [1:0] lc3b_mem_wmask;

	// operations as they reach the memory stage.
	typedef enum logic [2:0]
	{
		NOP,
		ALU,
		LDR,
		STR,
		LDB,
		STB,
		LDI,
		STI
	} lc3b_opcode;

	// an indirect access spends one pass in each state.
	typedef enum logic
	{
		FIRST_ACCESS,
		SECOND_ACCESS
	} access_state;

	localparam int MEM_ADDR_BITS = 8; // word-address bits the data memory decodes.
	localparam int MEM_WORDS = 2 ** MEM_ADDR_BITS;
	localparam int MEM_LATENCY = 2; // cycles from the first request cycle to resp.
	localparam int MEM_COUNT_BITS = $clog2(MEM_LATENCY + 1);

	// true for every operation that touches the data memory.
	function automatic logic is_mem_op(input lc3b_opcode op);
		return (op != NOP) && (op != ALU);
	endfunction

	function automatic logic is_load(input lc3b_opcode op);
		return (op == LDR) || (op == LDB) || (op == LDI);
	endfunction

	function automatic logic is_store(input lc3b_opcode op);
		return (op == STR) || (op == STB) || (op == STI);
	endfunction

	// indirect operations fetch a pointer before the real access.
	function automatic logic is_indirect(input lc3b_opcode op);
		return (op == LDI) || (op == STI);
	endfunction

endpackage : lc3b_types

//--- mem_bus_if.sv
`timescale 1ns/100ps

interface mem_bus_if import lc3b_types::*; ();

	lc3b_word address; // byte address.
	lc3b_word wdata;
	lc3b_mem_wmask wmask;
	logic read;
	logic write;
	lc3b_word rdata;
	logic resp; // one-cycle pulse when the access is finished.

	// the memory stage side issues requests.
	modport master
	(
		output address, wdata, wmask, read, write,
		input rdata, resp
	);

	// the data memory answers them.
	modport slave
	(
		input address, wdata, wmask, read, write,
		output rdata, resp
	);

endinterface : mem_bus_if

//--- mem_access_fsm.sv
`timescale 1ns/100ps

module mem_access_fsm import lc3b_types::*;
(
	input logic clk,
	input logic rst_n,
	input lc3b_opcode opcode,
	input lc3b_word alu_out,
	input lc3b_word rdata,
	input logic resp,
	output lc3b_word address,
	output logic read,
	output logic write,
	output logic done
);

	access_state state;
	access_state state_next;
	lc3b_word pointer; // address fetched by the first half of LDI and STI.
	logic mem_op;
	logic indirect;
	logic final_access;

	assign mem_op = is_mem_op(opcode);
	assign indirect = is_indirect(opcode);

	// a direct access is always final; an indirect one only in its second pass.
	assign final_access = !indirect || (state == SECOND_ACCESS);

	assign address = (state == SECOND_ACCESS) ? pointer : alu_out;

	// the pointer fetch of STI is a read, the store itself comes second.
	always_comb
	begin
		read = 1'b0;
		write = 1'b0;
		if (mem_op)
		begin
			if (!final_access)
				read = 1'b1;
			else if (is_store(opcode))
				write = 1'b1;
			else
				read = 1'b1;
		end
	end

	assign done = mem_op && final_access && resp;

	always_comb
	begin
		state_next = state;
		case (state)
			FIRST_ACCESS:
			begin
				if (mem_op && indirect && resp)
					state_next = SECOND_ACCESS;
			end
			SECOND_ACCESS:
			begin
				if (resp)
					state_next = FIRST_ACCESS; // ready for the next instruction.
			end
			default:
				state_next = FIRST_ACCESS;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= FIRST_ACCESS;
		else
			state <= state_next;
	end

	// the pointer arrives with the first resp of an indirect access.
	always_ff @(posedge clk)
	begin
		if (mem_op && indirect && resp && (state == FIRST_ACCESS))
			pointer <= rdata;
	end

endmodule : mem_access_fsm

//--- byte_lane_unit.sv
`timescale 1ns/100ps

module byte_lane_unit import lc3b_types::*;
(
	input lc3b_opcode opcode,
	input logic address_lsb,
	input lc3b_word srcb,
	input lc3b_word rdata,
	output lc3b_word wdata,
	output lc3b_mem_wmask wmask,
	output lc3b_word load_data
);

	logic [7:0] read_byte;

	// store side.
	always_comb
	begin
		wdata = srcb;
		wmask = 2'b00;
		case (opcode)
			STB:
			begin
				// the byte goes out on both lanes and the mask picks one.
				wdata = {srcb[7:0], srcb[7:0]};
				wmask = address_lsb ? 2'b10 : 2'b01;
			end
			STR, STI:
				wmask = 2'b11;
			default:
				wmask = 2'b00; // nothing is written.
		endcase
	end

	// odd byte addresses live in the high lane.
	assign read_byte = address_lsb ? rdata[15:8] : rdata[7:0];

	always_comb
	begin
		if (opcode == LDB)
			load_data = {8'h00, read_byte}; // zero-extended.
		else
			load_data = rdata;
	end

endmodule : byte_lane_unit

//--- mem_stage.sv
`timescale 1ns/100ps

module mem_stage import lc3b_types::*;
(
	input logic clk,
	input logic rst_n,
	input lc3b_opcode ex_opcode,
	input lc3b_word ex_alu_out,
	input lc3b_word ex_srcb,
	input lc3b_word ex_pc,
	mem_bus_if.master bus,
	output logic stall,
	output lc3b_opcode wb_opcode,
	output lc3b_word wb_pc,
	output lc3b_word wb_alu_out,
	output lc3b_word wb_mem_data
);

	lc3b_word access_address;
	lc3b_word store_data;
	lc3b_word load_data;
	lc3b_word mem_data;
	lc3b_mem_wmask store_mask;
	logic access_read;
	logic access_write;
	logic access_done;

	mem_access_fsm i_mem_access_fsm
	(
		.clk(clk),
		.rst_n(rst_n),
		.opcode(ex_opcode),
		.alu_out(ex_alu_out),
		.rdata(bus.rdata),
		.resp(bus.resp),
		.address(access_address),
		.read(access_read),
		.write(access_write),
		.done(access_done)
	);

	// the lane follows whichever address is on the bus right now.
	byte_lane_unit i_byte_lane_unit
	(
		.opcode(ex_opcode),
		.address_lsb(access_address[0]),
		.srcb(ex_srcb),
		.rdata(bus.rdata),
		.wdata(store_data),
		.wmask(store_mask),
		.load_data(load_data)
	);

	assign bus.address = access_address;
	assign bus.wdata = store_data;
	assign bus.wmask = store_mask;
	assign bus.read = access_read;
	assign bus.write = access_write;

	// a memory operation holds the pipe until its final resp.
	assign stall = is_mem_op(ex_opcode) && !access_done;

	assign mem_data = is_load(ex_opcode) ? load_data : store_data;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wb_opcode <= NOP;
			wb_pc <= '0;
			wb_alu_out <= '0;
			wb_mem_data <= '0;
		end
		else if (!stall)
		begin
			wb_opcode <= ex_opcode;
			wb_pc <= ex_pc;
			wb_alu_out <= ex_alu_out;
			wb_mem_data <= mem_data; // rdata is valid in the resp cycle.
		end
	end

endmodule : mem_stage

//--- data_memory.sv
`timescale 1ns/100ps

module data_memory import lc3b_types::*;
(
	input logic clk,
	input logic rst_n,
	mem_bus_if.slave bus
);

	lc3b_word mem [MEM_WORDS];
	lc3b_word rdata_q;
	logic [MEM_ADDR_BITS-1:0] word_addr;
	logic [MEM_COUNT_BITS-1:0] delay_count; // cycles the current request has waited.
	logic resp_q;
	logic request;
	logic last_wait;

	assign word_addr = bus.address[MEM_ADDR_BITS:1]; // bit 0 selects a byte lane.
	assign request = bus.read || bus.write;

	// the edge at the end of this cycle starts the resp cycle.
	assign last_wait = request && !resp_q &&
		(delay_count == MEM_COUNT_BITS'(MEM_LATENCY - 1));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			delay_count <= '0;
			resp_q <= 1'b0;
		end
		else if (resp_q)
		begin
			delay_count <= '0; // a new request may follow right away.
			resp_q <= 1'b0;
		end
		else if (request)
		begin
			delay_count <= delay_count + 1'b1;
			resp_q <= last_wait;
		end
	end

	// the masked write lands together with the resp pulse.
	always_ff @(posedge clk)
	begin
		if (last_wait && bus.write)
		begin
			if (bus.wmask[0])
				mem[word_addr][7:0] <= bus.wdata[7:0];
			if (bus.wmask[1])
				mem[word_addr][15:8] <= bus.wdata[15:8];
		end
		else if (last_wait)
			rdata_q <= mem[word_addr];
	end

	assign bus.rdata = rdata_q;
	assign bus.resp = resp_q;

endmodule : data_memory

//--- lc3b_mem_top.sv
`timescale 1ns/100ps

module lc3b_mem_top import lc3b_types::*;
(
	input logic clk,
	input logic rst_n,
	input lc3b_opcode ex_opcode,
	input lc3b_word ex_alu_out,
	input lc3b_word ex_srcb,
	input lc3b_word ex_pc,
	output logic stall,
	output lc3b_opcode wb_opcode,
	output lc3b_word wb_pc,
	output lc3b_word wb_alu_out,
	output lc3b_word wb_mem_data
);

	mem_bus_if bus ();

	// the stage masters the bus.
	mem_stage i_mem_stage
	(
		.clk(clk),
		.rst_n(rst_n),
		.ex_opcode(ex_opcode),
		.ex_alu_out(ex_alu_out),
		.ex_srcb(ex_srcb),
		.ex_pc(ex_pc),
		.bus(bus.master),
		.stall(stall),
		.wb_opcode(wb_opcode),
		.wb_pc(wb_pc),
		.wb_alu_out(wb_alu_out),
		.wb_mem_data(wb_mem_data)
	);

	data_memory i_data_memory
	(
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus.slave)
	);

endmodule : lc3b_mem_top

//--- mem_stage_properties.sv
`timescale 1ns/100ps

module mem_stage_properties import lc3b_types::*;
(
	input logic clk,
	input logic rst_n,
	input lc3b_word address,
	input lc3b_word wdata,
	input lc3b_mem_wmask wmask,
	input logic read,
	input logic write,
	input logic resp,
	input logic stall
);

	// an access is either a read or a write.
	read_write_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(read && write))
	else
		$error("read and write are high in the same cycle");

	// the request must not move while the memory is still counting.
	request_stable: assert property (@(posedge clk) disable iff (!rst_n)
		((read || write) && !resp) |=> ($stable(address) && $stable(wdata) &&
		$stable(wmask) && $stable(read) && $stable(write)))
	else
		$error("request changed before resp");

	// a request starts after an idle cycle or right after the previous resp.
	resp_latency: assert property (@(posedge clk) disable iff (!rst_n)
		((read || write) && ($past(resp) || !$past(read || write))) |->
		##MEM_LATENCY resp)
	else
		$error("resp did not arrive %0d cycles after the request", MEM_LATENCY);

	// the stage and the memory both come out of reset idle.
	stall_low_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> (!stall && !read && !write && !resp))
	else
		$error("stall, a request or resp is high right after reset");

endmodule : mem_stage_properties

bind mem_stage mem_stage_properties i_mem_stage_properties
(
	.clk(clk),
	.rst_n(rst_n),
	.address(bus.address),
	.wdata(bus.wdata),
	.wmask(bus.wmask),
	.read(bus.read),
	.write(bus.write),
	.resp(bus.resp),
	.stall(stall)
);

//--- tb_lc3b_mem_top.sv
`timescale 1ns/100ps

module tb_lc3b_mem_top import lc3b_types::*; ();

	typedef logic [MEM_ADDR_BITS-1:0] word_index_t;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_PASS = 8;
	localparam int NUM_WORDS = 8;
	localparam int NUM_BYTES = 4;
	localparam int NUM_INDIRECT = 3;
	localparam int NUM_BURST = 10;
	localparam int INSTR_COUNT = 1 + NUM_PASS + 2 * NUM_WORDS + 4 * NUM_BYTES +
		4 * NUM_INDIRECT + NUM_BURST;
	localparam int WAIT_LIMIT = 4 * (MEM_LATENCY + 1); // per instruction, far above the worst case.
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + INSTR_COUNT * 2 * (MEM_LATENCY + 1) + 100;

	logic clk;
	logic rst_n;
	lc3b_opcode ex_opcode;
	lc3b_word ex_alu_out;
	lc3b_word ex_srcb;
	lc3b_word ex_pc;
	logic stall;
	lc3b_opcode wb_opcode;
	lc3b_word wb_pc;
	lc3b_word wb_alu_out;
	lc3b_word wb_mem_data;

	lc3b_word model_mem [MEM_WORDS]; // reference copy of the data memory.
	lc3b_word pc_counter;
	integer seed;
	logic count_enable;
	int completions = 0;
	int errors = 0;
	int checks = 0;

	lc3b_mem_top i_lc3b_mem_top
	(
		.clk(clk),
		.rst_n(rst_n),
		.ex_opcode(ex_opcode),
		.ex_alu_out(ex_alu_out),
		.ex_srcb(ex_srcb),
		.ex_pc(ex_pc),
		.stall(stall),
		.wb_opcode(wb_opcode),
		.wb_pc(wb_pc),
		.wb_alu_out(wb_alu_out),
		.wb_mem_data(wb_mem_data)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// every edge with stall low retires one instruction into the writeback register.
	always @(posedge clk)
	begin
		if (rst_n && count_enable && !stall)
			completions <= completions + 1;
	end

	function automatic lc3b_word rand_word();
		return lc3b_word'($random(seed));
	endfunction

	// byte address to word slot, bit 0 only picks the lane.
	function automatic word_index_t word_index(input lc3b_word addr);
		return addr[MEM_ADDR_BITS:1];
	endfunction

	task automatic check_word(input string name, input lc3b_word actual, input lc3b_word expected);
		checks++;
		assert (actual == expected)
		else
		begin
			$display("error: %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// presents one instruction at a falling edge and checks what reaches writeback.
	task automatic run_instr(input lc3b_opcode op, input lc3b_word alu, input lc3b_word srcb);
		lc3b_word pc;
		lc3b_word word;
		lc3b_word target;
		lc3b_word exp_data;
		logic check_data;
		int exp_waits;
		int waits;
		pc = pc_counter;
		pc_counter = pc_counter + 16'd2;
		exp_data = '0;
		check_data = 1'b1;
		exp_waits = MEM_LATENCY;
		case (op)
			LDR:
				exp_data = model_mem[word_index(alu)];
			LDB:
			begin
				word = model_mem[word_index(alu)];
				exp_data = alu[0] ? {8'h00, word[15:8]} : {8'h00, word[7:0]};
			end
			LDI:
			begin
				target = model_mem[word_index(alu)]; // the pointer, then the data it names.
				exp_data = model_mem[word_index(target)];
				exp_waits = 2 * MEM_LATENCY + 1;
			end
			STR:
			begin
				model_mem[word_index(alu)] = srcb;
				exp_data = srcb;
			end
			STB:
			begin
				if (alu[0])
					model_mem[word_index(alu)][15:8] = srcb[7:0];
				else
					model_mem[word_index(alu)][7:0] = srcb[7:0];
				exp_data = {srcb[7:0], srcb[7:0]};
			end
			STI:
			begin
				target = model_mem[word_index(alu)];
				model_mem[word_index(target)] = srcb;
				exp_data = srcb;
				exp_waits = 2 * MEM_LATENCY + 1;
			end
			default:
			begin
				check_data = 1'b0;
				exp_waits = 0; // NOP and ALU never stall.
			end
		endcase
		ex_opcode = op;
		ex_alu_out = alu;
		ex_srcb = srcb;
		ex_pc = pc;
		#1;
		waits = 0;
		while (stall && waits < WAIT_LIMIT)
		begin
			@(negedge clk);
			waits++;
		end
		if (stall)
		begin
			$display("stall stayed high for %0d cycles on opcode %s", waits, op.name());
			errors++;
		end
		checks++;
		assert (waits == exp_waits)
		else
		begin
			$display("error: stall cycles expected %h actual %h", exp_waits, waits);
			errors++;
		end
		@(posedge clk);
		@(negedge clk);
		checks++;
		assert (wb_opcode == op)
		else
		begin
			$display("error: wb_opcode expected %h actual %h", op, wb_opcode);
			errors++;
		end
		check_word("wb_pc", wb_pc, pc);
		check_word("wb_alu_out", wb_alu_out, alu);
		if (check_data)
			check_word("wb_mem_data", wb_mem_data, exp_data);
	endtask

	task automatic after_reset();
		checks++;
		assert (!stall)
		else
		begin
			$display("error: stall expected %h actual %h", 1'b0, stall);
			errors++;
		end
		checks++;
		assert (wb_opcode == NOP)
		else
		begin
			$display("error: wb_opcode expected %h actual %h", NOP, wb_opcode);
			errors++;
		end
		check_word("wb_pc", wb_pc, 16'h0000);
		check_word("wb_alu_out", wb_alu_out, 16'h0000);
		check_word("wb_mem_data", wb_mem_data, 16'h0000);
		run_instr(NOP, 16'h0000, 16'h0000);
	endtask

	task automatic pass_through_ops();
		int i;
		for (i = 0; i < NUM_PASS; i++)
		begin
			if (i % 2 == 0)
				run_instr(ALU, rand_word(), rand_word());
			else
				run_instr(NOP, rand_word(), rand_word());
		end
	endtask

	task automatic word_store_load();
		lc3b_word addr [NUM_WORDS];
		int i;
		for (i = 0; i < NUM_WORDS; i++)
		begin
			addr[i] = rand_word() & 16'hfffe;
			run_instr(STR, addr[i], rand_word());
		end
		for (i = 0; i < NUM_WORDS; i++)
			run_instr(LDR, addr[i], rand_word());
	endtask

	// the full word is written first so the untouched lane holds a known value.
	task automatic byte_store_load();
		lc3b_word base;
		lc3b_word byte_addr;
		int i;
		for (i = 0; i < NUM_BYTES; i++)
		begin
			base = rand_word() & 16'hfffe;
			byte_addr = base | lc3b_word'(i % 2);
			run_instr(STR, base, rand_word());
			run_instr(STB, byte_addr, rand_word());
			run_instr(LDB, byte_addr, rand_word());
			run_instr(LDR, base, rand_word());
		end
	endtask

	task automatic indirect_store_load();
		lc3b_word ptr_loc;
		lc3b_word target;
		int i;
		for (i = 0; i < NUM_INDIRECT; i++)
		begin
			ptr_loc = rand_word() & 16'hfffe;
			do
			begin
				target = rand_word() & 16'hfffe;
			end
			while (word_index(target) == word_index(ptr_loc));
			run_instr(STR, ptr_loc, target);
			run_instr(STI, ptr_loc, rand_word());
			run_instr(LDI, ptr_loc, rand_word());
			run_instr(LDR, target, rand_word());
		end
	endtask

	task automatic back_to_back();
		lc3b_word addr;
		lc3b_word ptr_loc;
		int start;
		addr = rand_word() & 16'hfffe;
		ptr_loc = addr ^ 16'h0100; // another word slot.
		count_enable = 1'b1;
		start = completions;
		run_instr(STR, addr, rand_word());
		run_instr(STR, ptr_loc, addr);
		run_instr(LDR, addr, rand_word());
		run_instr(STB, addr | 16'h0001, rand_word());
		run_instr(LDB, addr | 16'h0001, rand_word());
		run_instr(ALU, rand_word(), rand_word());
		run_instr(STI, ptr_loc, rand_word());
		run_instr(LDI, ptr_loc, rand_word());
		run_instr(LDB, addr, rand_word());
		run_instr(NOP, rand_word(), rand_word());
		count_enable = 1'b0;
		checks++;
		assert (completions - start == NUM_BURST)
		else
		begin
			$display("error: completions expected %h actual %h", NUM_BURST, completions - start);
			errors++;
		end
	endtask

	initial
	begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial
	begin
		seed = 44;
		rst_n = 1'b0;
		ex_opcode = NOP;
		ex_alu_out = '0;
		ex_srcb = '0;
		ex_pc = '0;
		count_enable = 1'b0;
		pc_counter = 16'h3000;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		after_reset();
		pass_through_ops();
		word_store_load();
		byte_store_load();
		indirect_store_load();
		back_to_back();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule : tb_lc3b_mem_top

//--- build.f
lc3b_types.sv
mem_bus_if.sv
mem_access_fsm.sv
byte_lane_unit.sv
mem_stage.sv
data_memory.sv
lc3b_mem_top.sv
mem_stage_properties.sv
tb_lc3b_mem_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_lc3b_mem_top
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then \
		echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
